//--- fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Instruction and PC width
`define FETCH_DATA_WIDTH 32

// Width of an rs or rt register field
`define FETCH_REG_WIDTH 5

// Program memory geometry, word addressed
`define FETCH_MEM_DEPTH 256
`define FETCH_ADDR_WIDTH 8

// Top six bits of a halt instruction
`define FETCH_HALT_OPCODE 6'b111111

`endif

//--- fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    // --------------------
    // Datapath types
    // --------------------

    // Instruction word or PC value
    typedef logic [`FETCH_DATA_WIDTH-1:0] word_t;

    // rs / rt register index
    typedef logic [`FETCH_REG_WIDTH-1:0] reg_addr_t;

    // Program memory word address
    typedef logic [`FETCH_ADDR_WIDTH-1:0] mem_addr_t;

    // --------------------
    // Control FSM
    // --------------------

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALTED
    } fetch_state_t;

endpackage

//--- fetch_ctrl_if.sv
interface fetch_ctrl_if;

    // Fetch happens on a rising edge where this is high
    logic fetch_enable;

    // One-cycle pulse, clears the PC
    logic pc_restart;

    // Memory writes permitted, idle state only
    logic load_enable;

    // Output stage currently presents a valid halt word
    logic halt_seen;

    modport control (
        output fetch_enable,
        output pc_restart,
        output load_enable,
        input  halt_seen
    );

    // Shared by PC, memory and output stage
    modport datapath (
        input  fetch_enable,
        input  pc_restart,
        input  load_enable,
        output halt_seen
    );

endinterface

//--- fetch_control.sv
module fetch_control (
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic          i_start,
    input  logic          i_execution_mode,
    input  logic          i_step,
    input  logic          i_stall,
    output logic          o_running,
    fetch_ctrl_if.control ctrl
);

    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         start_accepted;
    logic         mode_allows;

    // Start is honoured only when not already running
    assign start_accepted = i_start && (state != ST_RUN);

    // Continuous mode always fetches, step mode waits for a step strobe
    assign mode_allows = !i_execution_mode || i_step;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                // Halt word on the output ends the run
                if (ctrl.halt_seen) begin
                    state_next = ST_HALTED;
                end
            end
            ST_HALTED: begin
                if (i_start) begin
                    state_next = ST_RUN;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // --------------------
    // Commands
    // --------------------

    // PC clears on the same edge that enters ST_RUN
    assign ctrl.pc_restart = start_accepted;

    assign ctrl.load_enable = (state == ST_IDLE);

    assign ctrl.fetch_enable = (state == ST_RUN)
                             && !ctrl.halt_seen
                             && !i_stall
                             && mode_allows;

    assign o_running = (state == ST_RUN);

    // A halt word on the output is the last fetch of the run
    a_no_fetch_after_halt: assert property (
        @(posedge i_clock) disable iff (i_reset)
        ctrl.halt_seen |=> !ctrl.fetch_enable
    ) else $error("fetch_enable high right after a halt word");

endmodule

//--- pc_unit.sv
module pc_unit (
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_pc_src,
    input  fetch_pkg::word_t i_pc_branch,
    output fetch_pkg::word_t o_pc,
    fetch_ctrl_if.datapath  ctrl
);

    import fetch_pkg::*;

    word_t pc;
    word_t pc_increment;

    // Word addressed, so the next sequential PC is one higher
    assign pc_increment = pc + word_t'(1);

    // --------------------
    // PC register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_reset || ctrl.pc_restart) begin
            pc <= '0;
        end else if (ctrl.fetch_enable) begin
            // Redirect from a later stage wins over the increment
            if (i_pc_src) begin
                pc <= i_pc_branch;
            end else begin
                pc <= pc_increment;
            end
        end
    end

    assign o_pc = pc;

    // Restart comes from idle or halted, where no fetch can happen
    a_restart_not_fetch: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(ctrl.pc_restart && ctrl.fetch_enable)
    ) else $error("pc_restart and fetch_enable high together");

endmodule

//--- program_memory.sv
`include "fetch_cfg.svh"

module program_memory (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_load_valid,
    input  fetch_pkg::word_t    i_load_data,
    input  fetch_pkg::mem_addr_t i_read_address,
    output fetch_pkg::word_t    o_read_data,
    fetch_ctrl_if.datapath      ctrl
);

    import fetch_pkg::*;

    word_t     mem [`FETCH_MEM_DEPTH];
    mem_addr_t load_pointer;
    word_t     read_data;
    logic      write_enable;

    // Host writes land only while the control is idle
    assign write_enable = i_load_valid && ctrl.load_enable;

    // --------------------
    // Load port
    // --------------------
    always_ff @(posedge i_clock) begin
        if (write_enable) begin
            mem[load_pointer] <= i_load_data;
        end
    end

    // Pointer wraps at the end of memory, cleared by reset only
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_pointer <= '0;
        end else if (write_enable) begin
            load_pointer <= load_pointer + mem_addr_t'(1);
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Holds the last fetched word between fetches
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            read_data <= '0;
        end else if (ctrl.fetch_enable) begin
            read_data <= mem[i_read_address];
        end
    end

    assign o_read_data = read_data;

    // Loading and fetching belong to different control states
    a_no_write_on_fetch: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(write_enable && ctrl.fetch_enable)
    ) else $error("program memory written during a fetch");

endmodule

//--- if_id_register.sv
`include "fetch_cfg.svh"

module if_id_register (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  fetch_pkg::word_t     i_pc,
    input  fetch_pkg::word_t     i_read_data,
    output logic                 o_valid,
    output logic                 o_halt,
    output fetch_pkg::word_t     o_pc_next,
    output fetch_pkg::word_t     o_instruction,
    output fetch_pkg::reg_addr_t o_rs,
    output fetch_pkg::reg_addr_t o_rt,
    fetch_ctrl_if.datapath       ctrl
);

    import fetch_pkg::*;

    localparam int unsigned OPCODE_WIDTH = 6;

    logic  valid;
    word_t pc_next;
    logic  is_halt;

    // --------------------
    // Fetch side registers
    // --------------------

    // Valid lines up with the memory's registered read
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid <= 1'b0;
        end else begin
            valid <= ctrl.fetch_enable;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc_next <= '0;
        end else if (ctrl.fetch_enable) begin
            pc_next <= i_pc + word_t'(1);
        end
    end

    // --------------------
    // Decode side view
    // --------------------
    assign is_halt = valid
                  && (i_read_data[`FETCH_DATA_WIDTH-1 -: OPCODE_WIDTH] == `FETCH_HALT_OPCODE);

    assign o_valid       = valid;
    assign o_halt        = is_halt;
    assign o_pc_next     = pc_next;
    assign o_instruction = i_read_data;
    assign o_rs          = i_read_data[25:21];
    assign o_rt          = i_read_data[20:16];

    // Tells the control to stop fetching this very cycle
    assign ctrl.halt_seen = is_halt;

endmodule

//--- fetch_subsystem.sv
`include "fetch_cfg.svh"

module fetch_subsystem (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_load_valid,
    input  logic                 i_start,
    input  logic                 i_execution_mode,
    input  logic                 i_step,
    input  logic                 i_stall,
    input  logic                 i_pc_src,
    input  fetch_pkg::word_t     i_load_data,
    input  fetch_pkg::word_t     i_pc_branch,
    output logic                 o_valid,
    output logic                 o_halt,
    output logic                 o_running,
    output fetch_pkg::word_t     o_pc_next,
    output fetch_pkg::word_t     o_instruction,
    output fetch_pkg::reg_addr_t o_rs,
    output fetch_pkg::reg_addr_t o_rt
);

    import fetch_pkg::*;

    word_t     pc;
    word_t     read_data;
    mem_addr_t read_address;

    fetch_ctrl_if ctrl_bus ();

    // Only the low PC bits reach the memory
    assign read_address = pc[`FETCH_ADDR_WIDTH-1:0];

    // --------------------
    // Control
    // --------------------
    fetch_control u_fetch_control (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_start          (i_start),
        .i_execution_mode (i_execution_mode),
        .i_step           (i_step),
        .i_stall          (i_stall),
        .o_running        (o_running),
        .ctrl             (ctrl_bus.control)
    );

    // --------------------
    // Datapath
    // --------------------
    pc_unit u_pc_unit (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_pc_src    (i_pc_src),
        .i_pc_branch (i_pc_branch),
        .o_pc        (pc),
        .ctrl        (ctrl_bus.datapath)
    );

    program_memory u_program_memory (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_load_valid   (i_load_valid),
        .i_load_data    (i_load_data),
        .i_read_address (read_address),
        .o_read_data    (read_data),
        .ctrl           (ctrl_bus.datapath)
    );

    if_id_register u_if_id_register (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_pc          (pc),
        .i_read_data   (read_data),
        .o_valid       (o_valid),
        .o_halt        (o_halt),
        .o_pc_next     (o_pc_next),
        .o_instruction (o_instruction),
        .o_rs          (o_rs),
        .o_rt          (o_rt),
        .ctrl          (ctrl_bus.datapath)
    );

endmodule

//--- tb_fetch_subsystem.sv
`include "fetch_cfg.svh"

module tb_fetch_subsystem;

    import fetch_pkg::*;

    // Program is 20 ordinary words followed by a halt word
    localparam int unsigned PROGRAM_LENGTH = 21;
    localparam int unsigned RUN_LIMIT      = 300;
    localparam int unsigned IDLE_AFTER_RUN = 4;
    localparam int unsigned RUN_COUNT      = 5;
    localparam int unsigned TOTAL_CYCLES   = 4 + PROGRAM_LENGTH
                                           + RUN_COUNT * (RUN_LIMIT + IDLE_AFTER_RUN + 2) + 10;
    localparam int unsigned TIMEOUT_TIME   = TOTAL_CYCLES * 10 + 1000;

    typedef struct packed {
        word_t       instruction;
        word_t       pc_next;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic        halt;
        int unsigned due_cycle;
    } expected_t;

    logic      i_clock;
    logic      i_reset;
    logic      i_load_valid;
    logic      i_start;
    logic      i_execution_mode;
    logic      i_step;
    logic      i_stall;
    logic      i_pc_src;
    word_t     i_load_data;
    word_t     i_pc_branch;
    logic      o_valid;
    logic      o_halt;
    logic      o_running;
    word_t     o_pc_next;
    word_t     o_instruction;
    reg_addr_t o_rs;
    reg_addr_t o_rt;

    // Reference model state
    word_t       program_copy [`FETCH_MEM_DEPTH];
    mem_addr_t   load_ptr;
    word_t       model_pc;
    logic        model_running;
    logic        halt_out;
    expected_t   expect_q [$];
    int unsigned fetch_count;

    int unsigned cycle_count = 0;
    int unsigned valid_seen = 0;
    int unsigned mismatch_errors = 0;
    int unsigned other_errors = 0;
    int unsigned outputs;
    int unsigned fetches_before;

    fetch_subsystem i_fetch_subsystem (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_load_valid     (i_load_valid),
        .i_start          (i_start),
        .i_execution_mode (i_execution_mode),
        .i_step           (i_step),
        .i_stall          (i_stall),
        .i_pc_src         (i_pc_src),
        .i_load_data      (i_load_data),
        .i_pc_branch      (i_pc_branch),
        .o_valid          (o_valid),
        .o_halt           (o_halt),
        .o_running        (o_running),
        .o_pc_next        (o_pc_next),
        .o_instruction    (o_instruction),
        .o_rs             (o_rs),
        .o_rt             (o_rt)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
    end

    // --------------------
    // Reference model
    // --------------------

    // Expected decode-side view of a fetch at the given PC
    function automatic expected_t reference_fetch(input word_t pc);
        expected_t result;
        word_t     word;
        word = program_copy[pc[`FETCH_ADDR_WIDTH-1:0]];
        result.instruction = word;
        result.pc_next     = pc + 1;
        result.rs          = word[25:21];
        result.rt          = word[20:16];
        result.halt        = (word[31:26] == `FETCH_HALT_OPCODE);
        result.due_cycle   = 0;
        return result;
    endfunction

    // Drives one cycle from a falling edge and steps the model across the next rising edge
    task automatic drive_cycle(input logic start, input logic stall, input logic step,
                               input logic pc_src, input word_t branch);
        logic      fetch;
        logic      next_halt_out;
        expected_t item;
        // Run state of the current cycle
        if (o_running !== model_running) begin
            $display("FAIL %0t: o_running %b, expected %b", $time, o_running, model_running);
            mismatch_errors++;
        end
        i_start     = start;
        i_stall     = stall;
        i_step      = step;
        i_pc_src    = pc_src;
        i_pc_branch = branch;
        fetch = model_running && !halt_out && !stall && (!i_execution_mode || step);
        next_halt_out = 1'b0;
        if (fetch) begin
            item = reference_fetch(model_pc);
            item.due_cycle = cycle_count + 1;
            expect_q.push_back(item);
            next_halt_out = item.halt;
            fetch_count++;
            if (pc_src) begin
                model_pc = branch;
            end else begin
                model_pc = model_pc + 1;
            end
        end
        // Start is ignored while running
        if (start && !model_running) begin
            model_running = 1'b1;
            model_pc = '0;
        end else if (model_running && halt_out) begin
            model_running = 1'b0;
        end
        halt_out = next_halt_out;
        @(negedge i_clock);
    endtask

    task automatic apply_reset();
        i_reset = 1'b1;
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        model_running = 1'b0;
        model_pc = '0;
        halt_out = 1'b0;
        load_ptr = '0;
        expect_q.delete();
    endtask

    task automatic load_word(input word_t data);
        i_load_valid = 1'b1;
        i_load_data = data;
        program_copy[load_ptr] = data;
        load_ptr = load_ptr + mem_addr_t'(1);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
        i_load_valid = 1'b0;
    endtask

    task automatic load_program();
        word_t word;
        for (int i = 0; i < int'(PROGRAM_LENGTH) - 1; i++) begin
            word = $urandom();
            // Keep ordinary words clear of the halt opcode
            if (word[31:26] == `FETCH_HALT_OPCODE) begin
                word[31] = 1'b0;
            end
            load_word(word);
        end
        word = $urandom();
        load_word({`FETCH_HALT_OPCODE, word[25:0]});
    endtask

    task automatic check_reset_state();
        if (o_valid !== 1'b0 || o_halt !== 1'b0 || o_running !== 1'b0) begin
            $display("FAIL %0t: control outputs not low after reset", $time);
            mismatch_errors++;
        end
        if (o_pc_next !== '0 || o_instruction !== '0 || o_rs !== '0 || o_rt !== '0) begin
            $display("FAIL %0t: data outputs not zero after reset", $time);
            mismatch_errors++;
        end
    endtask

    // Start pulse, then random stall, branch and step stimulus until the halt
    task automatic run_program(input int unsigned stall_pct, input int unsigned branch_pct,
                               input int unsigned branch_budget, output int unsigned count);
        int unsigned cycles;
        int unsigned branches_left;
        int unsigned valid_before;
        logic        stall;
        logic        step;
        logic        pc_src;
        word_t       target;
        valid_before = valid_seen;
        branches_left = branch_budget;
        cycles = 0;
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
        while (model_running && cycles < RUN_LIMIT) begin
            stall = ($urandom_range(99) < stall_pct);
            step = i_execution_mode && ($urandom_range(99) < 50);
            pc_src = 1'b0;
            target = '0;
            if (branches_left > 0 && $urandom_range(99) < branch_pct) begin
                pc_src = 1'b1;
                target = $urandom_range(PROGRAM_LENGTH - 1);
                branches_left--;
            end
            drive_cycle(1'b0, stall, step, pc_src, target);
            cycles++;
        end
        if (model_running) begin
            $display("Program did not reach its halt within %0d cycles", RUN_LIMIT);
            other_errors++;
        end
        // Nothing more may appear once halted
        repeat (IDLE_AFTER_RUN) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
        if (o_running !== 1'b0) begin
            $display("FAIL %0t: o_running still high after halt", $time);
            mismatch_errors++;
        end
        count = valid_seen - valid_before;
    endtask

    task automatic check_output_count(input int unsigned got, input int unsigned want);
        if (got != want) begin
            $display("FAIL %0t: %0d valid outputs, expected %0d", $time, got, want);
            mismatch_errors++;
        end
    endtask

    // --------------------
    // Comparing process
    // --------------------
    always @(negedge i_clock) begin : compare_outputs
        expected_t item;
        if (o_valid === 1'b1) begin
            valid_seen++;
            if (expect_q.size() == 0) begin
                $display("Valid output at %0t without any fetch pending", $time);
                other_errors++;
            end else begin
                item = expect_q.pop_front();
                if (item.due_cycle != cycle_count) begin
                    $display("FAIL %0t: output arrived at cycle %0d, expected cycle %0d",
                             $time, cycle_count, item.due_cycle);
                    mismatch_errors++;
                end
                if (o_instruction !== item.instruction) begin
                    $display("FAIL %0t: o_instruction %h, expected %h",
                             $time, o_instruction, item.instruction);
                    mismatch_errors++;
                end
                if (o_pc_next !== item.pc_next) begin
                    $display("FAIL %0t: o_pc_next %h, expected %h",
                             $time, o_pc_next, item.pc_next);
                    mismatch_errors++;
                end
                if (o_rs !== item.rs || o_rt !== item.rt) begin
                    $display("FAIL %0t: rs/rt %0d/%0d, expected %0d/%0d",
                             $time, o_rs, o_rt, item.rs, item.rt);
                    mismatch_errors++;
                end
                if (o_halt !== item.halt) begin
                    $display("FAIL %0t: o_halt %b, expected %b", $time, o_halt, item.halt);
                    mismatch_errors++;
                end
            end
        end else begin
            if (o_halt === 1'b1) begin
                $display("FAIL %0t: o_halt high without o_valid", $time);
                mismatch_errors++;
            end
            if (expect_q.size() != 0 && expect_q[0].due_cycle <= cycle_count) begin
                $display("Expected valid output missing at %0t", $time);
                other_errors++;
                item = expect_q.pop_front();
            end
        end
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        #(TIMEOUT_TIME);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        void'($urandom(48733));
        i_reset = 1'b1;
        i_load_valid = 1'b0;
        i_start = 1'b0;
        i_execution_mode = 1'b0;
        i_step = 1'b0;
        i_stall = 1'b0;
        i_pc_src = 1'b0;
        i_load_data = '0;
        i_pc_branch = '0;
        fetch_count = 0;
        for (int i = 0; i < `FETCH_MEM_DEPTH; i++) begin
            program_copy[i] = '0;
        end

        apply_reset();
        check_reset_state();
        load_program();

        // Continuous run
        run_program(0, 0, 0, outputs);
        check_output_count(outputs, PROGRAM_LENGTH);

        // Restart with random stalls
        run_program(30, 0, 0, outputs);
        check_output_count(outputs, PROGRAM_LENGTH);

        // A few redirects to random in-program targets
        fetches_before = fetch_count;
        run_program(0, 25, 3, outputs);
        check_output_count(outputs, fetch_count - fetches_before);

        // Step mode
        i_execution_mode = 1'b1;
        run_program(0, 0, 0, outputs);
        check_output_count(outputs, PROGRAM_LENGTH);
        i_execution_mode = 1'b0;

        // Plain replay after a step-mode halt
        run_program(0, 0, 0, outputs);
        check_output_count(outputs, PROGRAM_LENGTH);

        repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
        if (expect_q.size() != 0) begin
            $display("%0d expected outputs never appeared", expect_q.size());
            other_errors++;
        end

        @(posedge i_clock);
        $display("Error counts: %0d value mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_subsystem.f
+incdir+.
fetch_pkg.sv
fetch_ctrl_if.sv
fetch_control.sv
pc_unit.sv
program_memory.sv
if_id_register.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fetch subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch_subsystem \
    -f fetch_subsystem.f -o sim_fetch_subsystem \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/sim_fetch_subsystem)"
echo "$sim_output"

echo "$sim_output" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
